// File: list.f
hw/mutative_types.sv
hw/way_store.sv
hw/tag_match.sv
hw/mutative_plru.sv
hw/cache_ctrl.sv
hw/mutative_cache.sv
dv/clk_gen.sv
dv/tb_mutative_cache.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert --timescale 1ns/1ps
TOP       ?= tb_mutative_cache
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT  = Test completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/tb_mutative_cache.sv
`timescale 1ns/1ps

module tb_mutative_cache;

    localparam int RANDOM_READS = 200;
    localparam int PLANNED_READS = 4 * (RANDOM_READS + 7) + 2 * 6 + 9 + 24;
    localparam int MAX_CYCLES = 60 * PLANNED_READS + 500; // margin for the four resets

    typedef struct packed {
        mutative_types::cache_address_t addr;
        logic                           hit;
        mutative_types::data_word_t     data;
        logic [31:0]                    cycle;
    } expect_t;

    logic                                 clk;
    logic                                 rst;
    mutative_types::setup_t               setup;
    logic                                 req;
    mutative_types::cache_address_t       addr;
    logic                                 busy;
    logic                                 rsp_valid;
    mutative_types::data_word_t           rsp_data;
    logic                                 rsp_hit;
    logic                                 mem_req;
    logic [mutative_types::ADDR_BITS-1:0] mem_addr;
    logic                                 mem_rsp_valid;
    mutative_types::data_word_t           mem_rsp_data;

    logic       model_valid [mutative_types::SET_SIZE][mutative_types::WAYS];
    logic [7:0] model_tag [mutative_types::SET_SIZE][mutative_types::WAYS];
    logic       model_used [mutative_types::SET_SIZE][mutative_types::WAYS];

    expect_t                              exp_q [$];
    expect_t                              front;
    string                                test_name;
    int unsigned                          cycle = 0;
    int unsigned                          last_fill_cycle;
    logic [31:0]                          want_cycle;
    logic                                 want_busy;
    bit                                   mem_req_seen;
    logic [mutative_types::ADDR_BITS-1:0] mem_pending;
    int                                   mem_delay;
    int                                   rsp_count = 0;
    int                                   data_errs = 0;
    int                                   hit_errs = 0;
    int                                   proto_errs = 0;
    int                                   model_errs = 0;
    int                                   victim;

    clk_gen clk_gen_i (.clk(clk));

    mutative_cache mutative_cache_i (
        .clk          (clk),
        .rst          (rst),
        .setup        (setup),
        .req          (req),
        .addr         (addr),
        .busy         (busy),
        .rsp_valid    (rsp_valid),
        .rsp_data     (rsp_data),
        .rsp_hit      (rsp_hit),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_rsp_valid(mem_rsp_valid),
        .mem_rsp_data (mem_rsp_data)
    );

    function automatic mutative_types::data_word_t mem_word(
        input logic [mutative_types::ADDR_BITS-1:0] a);
        logic [31:0] x;
        x = {20'h0, a} * 32'h9e3779b1;
        return x ^ {a, a[7:0], a} ^ 32'h5c3a0000;
    endfunction

    function automatic int ways_in_group(input mutative_types::setup_t mode);
        return 1 << int'(mode);
    endfunction

    // low (3 - mode) tag bits times the group size
    function automatic int group_first_way(input mutative_types::setup_t mode,
                                           input logic [7:0] tag);
        return (int'(tag) & ((8 >> int'(mode)) - 1)) * ways_in_group(mode);
    endfunction

    function automatic mutative_types::cache_address_t make_addr(input logic [7:0] tag,
                                                                 input logic [3:0] set_index);
        mutative_types::cache_address_t a;
        a.tag = tag;
        a.set_index = set_index;
        return a;
    endfunction

    function automatic void clear_model();
        for (int s = 0; s < mutative_types::SET_SIZE; s++) begin
            for (int w = 0; w < mutative_types::WAYS; w++) begin
                model_valid[s][w] = 1'b0;
                model_tag[s][w] = '0;
                model_used[s][w] = 1'b0;
            end
        end
    endfunction

    function automatic void mark_used(input int s, input int base, input int size,
                                      input int way);
        bit last;
        if (!model_used[s][way]) begin
            last = 1'b1;
            for (int w = base; w < base + size; w++) begin
                if (w != way && !model_used[s][w]) begin
                    last = 1'b0;
                end
            end
            if (last) begin
                for (int w = base; w < base + size; w++) begin
                    model_used[s][w] = 1'b0; // group full, start over
                end
            end
            model_used[s][way] = 1'b1;
        end
    endfunction

    function automatic bit predict_hit(input mutative_types::setup_t mode,
                                       input mutative_types::cache_address_t a,
                                       output int evict);
        int s;
        int base;
        int size;
        int way;
        bit found;
        s = int'(a.set_index);
        base = group_first_way(mode, a.tag);
        size = ways_in_group(mode);
        found = 1'b0;
        way = base;
        for (int w = base; w < base + size; w++) begin
            if (!found && model_valid[s][w] && model_tag[s][w] == a.tag) begin
                found = 1'b1;
                way = w;
            end
        end
        evict = base;
        if (!found) begin
            if (mode != mutative_types::MODE_DM) begin
                for (int w = base + size - 1; w >= base; w--) begin
                    if (!model_used[s][w]) begin
                        evict = w; // lowest clear bit wins
                    end
                end
            end
            way = evict;
            model_valid[s][way] = 1'b1;
            model_tag[s][way] = a.tag;
        end
        if (mode != mutative_types::MODE_DM) begin
            mark_used(s, base, size, way);
        end
        return found;
    endfunction

    task automatic wait_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic restart(input mutative_types::setup_t mode);
        test_name = "reset";
        rst = 1'b1;
        setup = mode;
        repeat (8) wait_cycle();
        rst = 1'b0;
        clear_model();
    endtask

    // want: 1 hit, 0 miss, -1 whatever the model says
    task automatic issue_read(input mutative_types::cache_address_t a, input int want,
                              input bit stray_on, input mutative_types::cache_address_t stray,
                              output int evict);
        expect_t e;
        bit      h;
        while (busy) begin
            wait_cycle();
        end
        h = predict_hit(setup, a, evict);
        if (want >= 0) begin
            assert (int'(h) == want) else begin
                $display("[FAIL] %s: model hit for %h expected %0d actual %0d",
                         test_name, a, want, h);
                model_errs++;
            end
        end
        e.addr = a;
        e.hit = h;
        e.data = mem_word(a);
        e.cycle = cycle;
        exp_q.push_back(e);
        req = 1'b1;
        addr = a;
        wait_cycle();
        req = 1'b0;
        if (stray_on) begin
            req = 1'b1; // busy now, must be dropped
            addr = stray;
            wait_cycle();
            req = 1'b0;
        end
        while (rsp_count < exp_q.size()) begin
            wait_cycle();
        end
    endtask

    task automatic read_word(input mutative_types::cache_address_t a, input int want);
        int v;
        issue_read(a, want, 1'b0, a, v);
    endtask

    task automatic thrash_two_way();
        test_name = "thrash_two_way";
        read_word(make_addr(8'h02, 4'd3), 0); // ways 4 and 5
        for (int i = 0; i < 6; i++) begin
            read_word(make_addr(8'(1 + 4 * (i % 3)), 4'd3), 0);
        end
        read_word(make_addr(8'h02, 4'd3), 1);
        read_word(make_addr(8'h09, 4'd3), 1);
    endtask

    task automatic fill_eight_ways();
        int evict;
        test_name = "fill_eight_ways";
        for (int p = 0; p < 2; p++) begin
            for (int t = 0; t < 8; t++) begin
                read_word(make_addr(8'(8'h40 + t), 4'd9), p);
            end
        end
        // ways 6 and 7 marked after the second pass
        issue_read(make_addr(8'h48, 4'd9), 0, 1'b0, '0, evict);
        assert (evict == 0) else begin
            $display("[FAIL] %s: victim way expected 0 actual %0d", test_name, evict);
            model_errs++;
        end
        read_word(make_addr(8'h40, 4'd9), 0);
        for (int t = 2; t < 8; t++) begin
            read_word(make_addr(8'(8'h40 + t), 4'd9), 1);
        end
    endtask

    task automatic print_counts();
        $display("errors: data %0d, hit %0d, protocol %0d, model %0d",
                 data_errs, hit_errs, proto_errs, model_errs);
    endtask

    // memory answers 1 to 6 cycles after mem_req
    initial begin
        mem_rsp_valid = 1'b0;
        mem_rsp_data = '0;
        forever begin
            @(negedge clk);
            if (!rst && mem_req) begin
                mem_pending = mem_addr;
                mem_delay = $urandom_range(1, 6);
                repeat (mem_delay) @(posedge clk);
                #1;
                mem_rsp_valid = 1'b1;
                mem_rsp_data = mem_word(mem_pending);
                @(posedge clk);
                #1;
                mem_rsp_valid = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            want_busy = 1'b0;
            if (rsp_count < exp_q.size()) begin
                front = exp_q[rsp_count];
                want_busy = (cycle > front.cycle);
            end
            assert (busy == want_busy) else begin
                $display("[FAIL] %s: busy expected %0b actual %0b", test_name, want_busy, busy);
                proto_errs++;
            end
            if (mem_rsp_valid) begin
                last_fill_cycle = cycle;
            end
            if (mem_req) begin
                assert (rsp_count < exp_q.size() && !mem_req_seen) else begin
                    $display("%s: mem_req pulsed with no fresh lookup", test_name);
                    proto_errs++;
                end
                assert (!front.hit) else begin
                    $display("[FAIL] %s: mem_req for %h expected 0 actual 1",
                             test_name, front.addr);
                    proto_errs++;
                end
                assert (mem_addr == front.addr) else begin
                    $display("[FAIL] %s: mem_addr expected %h actual %h",
                             test_name, front.addr, mem_addr);
                    proto_errs++;
                end
                mem_req_seen = 1'b1;
            end
            if (rsp_valid) begin
                assert (rsp_count < exp_q.size()) else begin
                    $display("%s: rsp_valid with no request outstanding", test_name);
                    proto_errs++;
                end
                if (rsp_count < exp_q.size()) begin
                    assert (rsp_hit == front.hit) else begin
                        $display("[FAIL] %s: rsp_hit for %h expected %0b actual %0b",
                                 test_name, front.addr, front.hit, rsp_hit);
                        hit_errs++;
                    end
                    assert (rsp_data == front.data) else begin
                        $display("[FAIL] %s: rsp_data for %h expected %h actual %h",
                                 test_name, front.addr, front.data, rsp_data);
                        data_errs++;
                    end
                    assert (front.hit || mem_req_seen) else begin
                        $display("%s: miss on %h answered without a memory read",
                                 test_name, front.addr);
                        proto_errs++;
                    end
                    want_cycle = front.hit ? front.cycle + 1 : last_fill_cycle + 1;
                    assert (cycle == want_cycle) else begin
                        $display("[FAIL] %s: response cycle expected %0d actual %0d",
                                 test_name, want_cycle, cycle);
                        proto_errs++;
                    end
                    mem_req_seen = 1'b0;
                    rsp_count++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout: run went past %0d cycles", MAX_CYCLES);
            print_counts();
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hdd82b058));
        rst = 1'b1;
        setup = mutative_types::MODE_DM;
        req = 1'b0;
        addr = '0;
        test_name = "reset";
        wait_cycle();
        for (int m = 0; m < 4; m++) begin
            restart(mutative_types::setup_t'(m));
            test_name = $sformatf("repeat_mode%0d", m);
            for (int s = 14; s < 16; s++) begin
                read_word(make_addr(8'hA0, 4'(s)), -1);
                read_word(make_addr(8'hA0, 4'(s)), 1);
            end
            test_name = $sformatf("busy_strobe_mode%0d", m);
            issue_read(make_addr(8'hC1, 4'd13), 0, 1'b1, make_addr(8'hC2, 4'd13), victim);
            issue_read(make_addr(8'hC1, 4'd13), 1, 1'b1, make_addr(8'hC3, 4'd13), victim);
            read_word(make_addr(8'hC2, 4'd13), 0);
            if (m == 0 || m == 3) begin
                test_name = $sformatf("same_set_pair_mode%0d", m);
                for (int i = 0; i < 6; i++) begin
                    read_word(make_addr((i % 2 == 0) ? 8'h03 : 8'h0B, 4'd5),
                              (m == 3 && i >= 2) ? 1 : 0); // 8-way keeps both
                end
            end
            if (m == 1) begin
                thrash_two_way();
            end
            if (m == 3) begin
                fill_eight_ways();
            end
            test_name = $sformatf("random_mode%0d", m);
            for (int i = 0; i < RANDOM_READS; i++) begin
                read_word(make_addr(8'($urandom_range(0, 23)), 4'($urandom_range(0, 3))), -1);
            end
        end
        repeat (5) wait_cycle();
        print_counts();
        if (data_errs + hit_errs + proto_errs + model_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: dv/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

endmodule

// File: hw/mutative_cache.sv
`timescale 1ns/1ps

module mutative_cache (
    input  logic                                 clk,
    input  logic                                 rst,
    input  mutative_types::setup_t               setup,
    input  logic                                 req,
    input  mutative_types::cache_address_t       addr,
    output logic                                 busy,
    output logic                                 rsp_valid,
    output mutative_types::data_word_t           rsp_data,
    output logic                                 rsp_hit,
    output logic                                 mem_req,
    output logic [mutative_types::ADDR_BITS-1:0] mem_addr,
    input  logic                                 mem_rsp_valid,
    input  mutative_types::data_word_t           mem_rsp_data
);

    mutative_types::cache_address_t          lookup_addr;
    logic                                    hit;
    logic [mutative_types::WAY_IDX_BITS-1:0] hit_way;
    logic [mutative_types::WAY_IDX_BITS-1:0] evict_way;
    logic [mutative_types::WAYS-1:0]         evict_we;
    logic [mutative_types::WAYS-1:0]         fill_we;
    logic                                    touch;
    logic [mutative_types::WAY_IDX_BITS-1:0] touch_way;
    mutative_types::tag_entry_t              tag_wdata;
    mutative_types::tag_entry_t              tag_rdata [mutative_types::WAYS];
    mutative_types::data_word_t              data_rdata [mutative_types::WAYS];

    assign tag_wdata = '{valid: 1'b1, tag: lookup_addr.tag};
    assign mem_addr = lookup_addr;
    assign rsp_data = data_rdata[hit_way]; // refill answers from the freshly written way

    cache_ctrl cache_ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .addr         (addr),
        .busy         (busy),
        .lookup_addr  (lookup_addr),
        .hit          (hit),
        .hit_way      (hit_way),
        .evict_way    (evict_way),
        .evict_we     (evict_we),
        .mem_req      (mem_req),
        .mem_rsp_valid(mem_rsp_valid),
        .fill_we      (fill_we),
        .touch        (touch),
        .touch_way    (touch_way),
        .rsp_valid    (rsp_valid),
        .rsp_hit      (rsp_hit)
    );

    way_store #(.payload(mutative_types::tag_entry_t)) tag_store (
        .clk      (clk),
        .rst      (rst),
        .set_index(lookup_addr.set_index),
        .we       (fill_we),
        .wdata    (tag_wdata),
        .rdata    (tag_rdata)
    );

    way_store #(.payload(mutative_types::data_word_t)) data_store (
        .clk      (clk),
        .rst      (rst),
        .set_index(lookup_addr.set_index),
        .we       (fill_we),
        .wdata    (mem_rsp_data),
        .rdata    (data_rdata)
    );

    tag_match tag_match_i (
        .setup  (setup),
        .addr   (lookup_addr),
        .tags   (tag_rdata),
        .hit    (hit),
        .hit_way(hit_way)
    );

    mutative_plru mutative_plru_i (
        .clk          (clk),
        .rst          (rst),
        .setup        (setup),
        .cache_address(lookup_addr),
        .touch        (touch),
        .touch_way    (touch_way),
        .evict_way    (evict_way),
        .evict_we     (evict_we)
    );

endmodule

// File: hw/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    req,
    input  mutative_types::cache_address_t          addr,
    output logic                                    busy,
    output mutative_types::cache_address_t          lookup_addr,
    input  logic                                    hit,
    input  logic [mutative_types::WAY_IDX_BITS-1:0] hit_way,
    input  logic [mutative_types::WAY_IDX_BITS-1:0] evict_way,
    input  logic [mutative_types::WAYS-1:0]         evict_we,
    output logic                                    mem_req,
    input  logic                                    mem_rsp_valid,
    output logic [mutative_types::WAYS-1:0]         fill_we,
    output logic                                    touch,
    output logic [mutative_types::WAY_IDX_BITS-1:0] touch_way,
    output logic                                    rsp_valid,
    output logic                                    rsp_hit
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WAIT_MEM
    } state_t;

    state_t                         state;
    mutative_types::cache_address_t addr_q;
    logic                           refill_q; // lookup after a fill answers as a miss
    logic                           fill;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            refill_q <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    state <= (hit || refill_q) ? ST_IDLE : ST_WAIT_MEM;
                    refill_q <= 1'b0;
                end
                ST_WAIT_MEM: begin
                    if (mem_rsp_valid) begin
                        state <= ST_LOOKUP;
                        refill_q <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req) begin
            addr_q <= addr;
        end
    end

    assign busy = (state != ST_IDLE);
    assign lookup_addr = addr_q;
    assign fill = (state == ST_WAIT_MEM) && mem_rsp_valid;
    assign fill_we = fill ? evict_we : '0;
    assign rsp_valid = (state == ST_LOOKUP) && (hit || refill_q);
    assign rsp_hit = (state == ST_LOOKUP) && hit && !refill_q;
    assign mem_req = (state == ST_LOOKUP) && !hit && !refill_q;
    assign touch = fill || rsp_hit;
    assign touch_way = fill ? evict_way : hit_way;

    // one request in flight, the next mem_req only after the answer
    assert property (@(posedge clk) disable iff (rst)
        mem_req |=> (state == ST_WAIT_MEM) && !mem_req)
        else $error("cache_ctrl: mem_req while waiting for memory");

    // the written way must hit on the replayed lookup
    assert property (@(posedge clk) disable iff (rst)
        fill |=> hit && (hit_way == $past(evict_way)))
        else $error("cache_ctrl: filled way does not hit after refill");

endmodule

// File: hw/mutative_plru.sv
`timescale 1ns/1ps

module mutative_plru (
    input  logic                                    clk,
    input  logic                                    rst,
    input  mutative_types::setup_t                  setup,
    input  mutative_types::cache_address_t          cache_address,
    input  logic                                    touch,
    input  logic [mutative_types::WAY_IDX_BITS-1:0] touch_way,
    output logic [mutative_types::WAY_IDX_BITS-1:0] evict_way,
    output logic [mutative_types::WAYS-1:0]         evict_we
);

    logic [mutative_types::WAYS-1:0] used_bits [mutative_types::SET_SIZE];

    logic [mutative_types::WAY_IDX_BITS-1:0] base;
    logic [mutative_types::WAYS-1:0]         grp_mask;
    logic [mutative_types::WAYS-1:0]         set_bits;
    logic [mutative_types::WAYS-1:0]         touch_bit;
    logic [mutative_types::WAYS-1:0]         next_bits;
    logic                                    do_update;

    assign base = mutative_types::group_base(setup, cache_address.tag);
    assign grp_mask = mutative_types::group_mask(setup, cache_address.tag);
    assign set_bits = used_bits[cache_address.set_index];
    assign touch_bit = mutative_types::WAYS'(1) << touch_way;

    // only a clear bit changes anything and dm ignores the bits
    assign do_update = touch && (setup != mutative_types::MODE_DM) && !set_bits[touch_way];

    always_comb begin
        next_bits = set_bits | touch_bit;
        if ((next_bits & grp_mask) == grp_mask) begin
            next_bits = (set_bits & ~grp_mask) | touch_bit; // last clear bit restarts the group
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < mutative_types::SET_SIZE; s++) begin
                used_bits[s] <= '0;
            end
        end else if (do_update) begin
            used_bits[cache_address.set_index] <= next_bits;
        end
    end

    // victim is the lowest clear way in the group
    always_comb begin
        evict_way = base;
        if (setup != mutative_types::MODE_DM) begin
            for (int w = mutative_types::WAYS - 1; w >= 0; w--) begin
                if (grp_mask[w] && !set_bits[w]) begin
                    evict_way = mutative_types::WAY_IDX_BITS'(w);
                end
            end
        end
    end

    assign evict_we = mutative_types::WAYS'(1) << evict_way;

    // hits and fills from the controller must stay in the addressed group
    assert property (@(posedge clk) disable iff (rst)
        touch |-> grp_mask[touch_way])
        else $error("mutative_plru: touch of way %0d outside group", touch_way);

    // victim mask names exactly one way of the active group
    assert property (@(posedge clk) disable iff (rst)
        $onehot(evict_we & grp_mask))
        else $error("mutative_plru: evict mask %b not one way of group %b", evict_we, grp_mask);

endmodule

// File: hw/tag_match.sv
`timescale 1ns/1ps

module tag_match (
    input  mutative_types::setup_t                  setup,
    input  mutative_types::cache_address_t          addr,
    input  mutative_types::tag_entry_t              tags [mutative_types::WAYS],
    output logic                                    hit,
    output logic [mutative_types::WAY_IDX_BITS-1:0] hit_way
);

    logic [mutative_types::WAYS-1:0] grp_mask;
    logic [mutative_types::WAYS-1:0] match;

    assign grp_mask = mutative_types::group_mask(setup, addr.tag);

    always_comb begin
        for (int w = 0; w < mutative_types::WAYS; w++) begin
            match[w] = grp_mask[w] && tags[w].valid && (tags[w].tag == addr.tag);
        end
    end

    assign hit = |match;

    // encoder, lowest matching way wins
    always_comb begin
        hit_way = '0;
        for (int w = mutative_types::WAYS - 1; w >= 0; w--) begin
            if (match[w]) begin
                hit_way = mutative_types::WAY_IDX_BITS'(w);
            end
        end
    end

    // fills only happen on a miss, so a tag never lands twice in a group
    always_comb begin
        assert final ($isunknown(match) || $onehot0(match))
            else $error("tag_match: tag %0h present in more than one way", addr.tag);
    end

endmodule

// File: hw/way_store.sv
`timescale 1ns/1ps

module way_store #(
    parameter type payload = logic [31:0]
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [mutative_types::SET_BITS-1:0] set_index,
    input  logic [mutative_types::WAYS-1:0]     we,
    input  payload                              wdata,
    output payload                              rdata [mutative_types::WAYS]
);

    payload mem [mutative_types::WAYS][mutative_types::SET_SIZE];

    always_ff @(posedge clk) begin
        if (rst) begin
            // tag store comes up all invalid
            for (int w = 0; w < mutative_types::WAYS; w++) begin
                for (int s = 0; s < mutative_types::SET_SIZE; s++) begin
                    mem[w][s] <= '0;
                end
            end
        end else begin
            for (int w = 0; w < mutative_types::WAYS; w++) begin
                if (we[w]) begin
                    mem[w][set_index] <= wdata;
                end
            end
        end
    end

    // async read of the addressed set, all ways
    always_comb begin
        for (int w = 0; w < mutative_types::WAYS; w++) begin
            rdata[w] = mem[w][set_index];
        end
    end

endmodule

// File: hw/mutative_types.sv
package mutative_types;

    localparam int WAYS = 8;
    localparam int WAY_IDX_BITS = 3;
    localparam int SET_SIZE = 16;
    localparam int SET_BITS = 4;
    localparam int TAG_BITS = 8;
    localparam int ADDR_BITS = 12;
    localparam int DATA_BITS = 32;

    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        logic [SET_BITS-1:0] set_index;
    } cache_address_t;

    typedef struct packed {
        logic                valid;
        logic [TAG_BITS-1:0] tag;
    } tag_entry_t;

    typedef logic [DATA_BITS-1:0] data_word_t;

    typedef enum logic [1:0] {
        MODE_DM,
        MODE_2WAY,
        MODE_4WAY,
        MODE_8WAY
    } setup_t;

    // ways per group: 1, 2, 4 or 8
    function automatic logic [WAY_IDX_BITS:0] group_size(setup_t mode);
        return {{WAY_IDX_BITS{1'b0}}, 1'b1} << mode;
    endfunction

    // low (3 - mode) tag bits pick the group
    function automatic logic [WAY_IDX_BITS-1:0] group_base(setup_t mode,
                                                           logic [TAG_BITS-1:0] tag);
        logic [WAY_IDX_BITS-1:0] low;
        low = tag[WAY_IDX_BITS-1:0] & ({WAY_IDX_BITS{1'b1}} >> mode);
        return low << mode;
    endfunction

    function automatic logic [WAYS-1:0] group_mask(setup_t mode, logic [TAG_BITS-1:0] tag);
        logic [WAYS-1:0] mask;
        int              base;
        int              size;
        base = int'(group_base(mode, tag));
        size = int'(group_size(mode));
        for (int w = 0; w < WAYS; w++) begin
            mask[w] = (w >= base) && (w < base + size);
        end
        return mask;
    endfunction

endpackage
